/* verilog/karatsuba_pkg.sv */
package karatsuba_pkg;

  // Widths ------------------------------
  parameter int OPERAND_W = 10;
  parameter int HALF_W    = 5;
  parameter int LUT_W     = 6;   // Half-sum plus its carry.
  parameter int PRODUCT_W = 20;

  // Controller states, one per schedule step.
  typedef enum logic [3:0] {
    IDLE,
    SUM_A,
    PROD_HI,
    PROD_LO,
    SUM_B,
    PROD_MID,
    SUB_LO,
    SUB_HI,
    HORNER_1,
    HORNER_2,
    DONE
  } ctrl_state_e;

  // ALU operand sources ------------------------------
  typedef enum logic [1:0] {
    A_REG1_HI,
    A_REG2_HI,
    A_REG3_SHIFTED,
    A_REG4
  } alu_a_sel_e;

  typedef enum logic [1:0] {
    B_REG1_LO,
    B_REG2_LO,
    B_REG3_SHIFTED,
    B_ALT            // reg1 or reg2, full width.
  } alu_b_sel_e;

endpackage

/* verilog/cla_adder.sv */
`timescale 1ns/1ps

module cla_adder #(
  parameter int WIDTH = 20
) (
  input  logic [WIDTH-1:0] a_i,
  input  logic [WIDTH-1:0] b_i,
  input  logic             sub_i,
  output logic [WIDTH-1:0] sum_o,
  output logic             carry_o
);

  localparam int NUM_GROUPS = WIDTH / 4;

  logic [WIDTH-1:0]    b_eff;
  logic [WIDTH-1:0]    g;
  logic [WIDTH-1:0]    p;
  logic [WIDTH-1:0]    c_bit;
  logic [NUM_GROUPS:0] c_grp;

  assign b_eff    = sub_i ? ~b_i : b_i;  // Two's complement subtract.
  assign g        = a_i & b_eff;
  assign p        = a_i ^ b_eff;
  assign c_grp[0] = sub_i;

  // Lookahead inside each group, ripple between groups.
  for (genvar k = 0; k < NUM_GROUPS; k++) begin : g_group
    logic [3:0] gg;
    logic [3:0] pp;
    logic       ci;

    assign gg = g[4*k +: 4];
    assign pp = p[4*k +: 4];
    assign ci = c_grp[k];

    assign c_bit[4*k]   = ci;
    assign c_bit[4*k+1] = gg[0] | (pp[0] & ci);
    assign c_bit[4*k+2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & ci);
    assign c_bit[4*k+3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                        | (pp[2] & pp[1] & pp[0] & ci);
    assign c_grp[k+1]   = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                        | (pp[3] & pp[2] & pp[1] & gg[0]) | ((&pp) & ci);
  end

  assign sum_o   = p ^ c_bit;
  assign carry_o = c_grp[NUM_GROUPS];

endmodule

/* verilog/mult_lut.sv */
`timescale 1ns/1ps

module mult_lut #(
  parameter int LUT_W = karatsuba_pkg::LUT_W
) (
  input  logic [2*LUT_W-1:0] addr_i,
  output logic [2*LUT_W-1:0] product_o
);

  localparam int ENTRY_W = 2 * LUT_W;
  localparam int DEPTH   = 2 ** ENTRY_W;

  logic [ENTRY_W-1:0] prod_table [DEPTH];

  // Upper address half times lower address half.
  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    localparam int OP_HI = i >> LUT_W;
    localparam int OP_LO = i % (2 ** LUT_W);

    assign prod_table[i] = ENTRY_W'(OP_HI * OP_LO);
  end

  assign product_o = prod_table[addr_i];

endmodule

/* verilog/karatsuba_10b_dp.sv */
`timescale 1ns/1ps

module karatsuba_10b_dp #(
  parameter int OPERAND_W = karatsuba_pkg::OPERAND_W,
  parameter int LUT_W     = karatsuba_pkg::LUT_W,
  parameter int PRODUCT_W = karatsuba_pkg::PRODUCT_W
) (
  input  logic                      clk,
  input  logic [OPERAND_W-1:0]      a_i,
  input  logic [OPERAND_W-1:0]      b_i,
  input  logic                      load_reg1_i,
  input  logic                      load_reg2_i,
  input  logic                      load_reg3_i,
  input  logic                      load_reg4_i,
  input  logic                      sel_reg1_i,
  input  logic                      sel_reg2_i,
  input  logic                      sel_reg3_i,
  input  logic                      sel_reg4_i,
  input  karatsuba_pkg::alu_a_sel_e sel_alu_a_i,
  input  karatsuba_pkg::alu_b_sel_e sel_alu_b_i,
  input  logic                      sel_alu_b2_i,
  input  logic                      shift5_i,
  input  logic                      sel_mult_a_i,
  input  logic                      sel_mult_a2_i,
  input  logic                      sel_mult_b_i,
  input  logic                      sel_mult_b1_i,
  input  logic                      sub_i,
  output logic [PRODUCT_W-1:0]      product_o
);

  localparam int HALF_W  = karatsuba_pkg::HALF_W;
  localparam int SHORT_W = 2 * LUT_W;  // reg1, reg4 and table output.

  logic [SHORT_W-1:0]   reg1_q;
  logic [PRODUCT_W-1:0] reg2_q;
  logic [PRODUCT_W-1:0] reg3_q;
  logic [SHORT_W-1:0]   reg4_q;

  logic [PRODUCT_W-1:0] reg3_shifted;
  logic [PRODUCT_W-1:0] alu_a;
  logic [PRODUCT_W-1:0] alu_b;
  logic [PRODUCT_W-1:0] alu_b2;
  logic [PRODUCT_W-1:0] adder_sum;
  logic                 adder_carry;

  logic [LUT_W-1:0]     mult_a1;
  logic [LUT_W-1:0]     mult_b1;
  logic [2*LUT_W-1:0]   mult_addr;
  logic [SHORT_W-1:0]   mult_prod;

  // Working registers ------------------------------
  always_ff @(posedge clk) begin
    if (load_reg1_i) reg1_q <= sel_reg1_i ? mult_prod : SHORT_W'(a_i);
    if (load_reg2_i) reg2_q <= sel_reg2_i ? adder_sum : PRODUCT_W'(b_i);
    if (load_reg3_i) reg3_q <= sel_reg3_i ? adder_sum : PRODUCT_W'(mult_prod);
    if (load_reg4_i) reg4_q <= sel_reg4_i ? adder_sum[SHORT_W-1:0] : mult_prod;
  end

  // ALU operands ------------------------------
  assign reg3_shifted = shift5_i ? (reg3_q << HALF_W) : reg3_q;
  assign alu_b2       = sel_alu_b2_i ? reg2_q : PRODUCT_W'(reg1_q);

  always_comb begin
    case (sel_alu_a_i)
      karatsuba_pkg::A_REG1_HI:      alu_a = PRODUCT_W'(reg1_q[OPERAND_W-1:HALF_W]);
      karatsuba_pkg::A_REG2_HI:      alu_a = PRODUCT_W'(reg2_q[OPERAND_W-1:HALF_W]);
      karatsuba_pkg::A_REG3_SHIFTED: alu_a = reg3_shifted;
      karatsuba_pkg::A_REG4:         alu_a = PRODUCT_W'(reg4_q);
      default:                       alu_a = '0;
    endcase
  end

  always_comb begin
    case (sel_alu_b_i)
      karatsuba_pkg::B_REG1_LO:      alu_b = PRODUCT_W'(reg1_q[HALF_W-1:0]);
      karatsuba_pkg::B_REG2_LO:      alu_b = PRODUCT_W'(reg2_q[HALF_W-1:0]);
      karatsuba_pkg::B_REG3_SHIFTED: alu_b = reg3_shifted;
      karatsuba_pkg::B_ALT:          alu_b = alu_b2;
      default:                       alu_b = '0;
    endcase
  end

  cla_adder #(
    .WIDTH (PRODUCT_W)
  ) u_adder (
    .a_i     (alu_a),
    .b_i     (alu_b),
    .sub_i   (sub_i),
    .sum_o   (adder_sum),
    .carry_o (adder_carry)
  );

  // Table address ------------------------------
  // Upper half of the address is the a side, lower half the b side.
  assign mult_a1 = sel_mult_a2_i ? reg4_q[LUT_W-1:0]
                                 : LUT_W'(reg1_q[OPERAND_W-1:HALF_W]);
  assign mult_b1 = sel_mult_b1_i ? reg2_q[LUT_W-1:0]
                                 : LUT_W'(reg2_q[OPERAND_W-1:HALF_W]);

  assign mult_addr[2*LUT_W-1:LUT_W] = sel_mult_a_i ? mult_a1
                                                   : LUT_W'(reg1_q[HALF_W-1:0]);
  assign mult_addr[LUT_W-1:0]       = sel_mult_b_i ? mult_b1
                                                   : LUT_W'(reg2_q[HALF_W-1:0]);

  mult_lut #(
    .LUT_W (LUT_W)
  ) u_lut (
    .addr_i    (mult_addr),
    .product_o (mult_prod)
  );

  assign product_o = reg3_q;

  // Both Karatsuba subtractions leave a non-negative middle term.
  a_no_borrow: assert property (@(posedge clk) (sub_i && load_reg4_i) |-> adder_carry)
    else $error("Borrow out of middle-term subtraction.");

endmodule

/* verilog/karatsuba_10b_ctrl.sv */
`timescale 1ns/1ps

module karatsuba_10b_ctrl (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      req_i,
  output logic                      ack_o,
  output logic                      load_reg1_o,
  output logic                      load_reg2_o,
  output logic                      load_reg3_o,
  output logic                      load_reg4_o,
  output logic                      sel_reg1_o,
  output logic                      sel_reg2_o,
  output logic                      sel_reg3_o,
  output logic                      sel_reg4_o,
  output karatsuba_pkg::alu_a_sel_e sel_alu_a_o,
  output karatsuba_pkg::alu_b_sel_e sel_alu_b_o,
  output logic                      sel_alu_b2_o,
  output logic                      shift5_o,
  output logic                      sel_mult_a_o,
  output logic                      sel_mult_a2_o,
  output logic                      sel_mult_b_o,
  output logic                      sel_mult_b1_o,
  output logic                      sub_o
);

  karatsuba_pkg::ctrl_state_e state_q;
  karatsuba_pkg::ctrl_state_e state_d;
  logic                       ack_q;
  logic                       ack_d;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= karatsuba_pkg::IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= ack_d;
    end
  end

  // Sequence ------------------------------
  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    case (state_q)
      karatsuba_pkg::IDLE:     if (req_i) state_d = karatsuba_pkg::SUM_A;
      karatsuba_pkg::SUM_A:    state_d = karatsuba_pkg::PROD_HI;
      karatsuba_pkg::PROD_HI:  state_d = karatsuba_pkg::PROD_LO;
      karatsuba_pkg::PROD_LO:  state_d = karatsuba_pkg::SUM_B;
      karatsuba_pkg::SUM_B:    state_d = karatsuba_pkg::PROD_MID;
      karatsuba_pkg::PROD_MID: state_d = karatsuba_pkg::SUB_LO;
      karatsuba_pkg::SUB_LO:   state_d = karatsuba_pkg::SUB_HI;
      karatsuba_pkg::SUB_HI:   state_d = karatsuba_pkg::HORNER_1;
      karatsuba_pkg::HORNER_1: state_d = karatsuba_pkg::HORNER_2;
      karatsuba_pkg::HORNER_2: state_d = karatsuba_pkg::DONE;
      karatsuba_pkg::DONE: begin
        // Hold ack until the requester drops req.
        if (ack_q && !req_i) state_d = karatsuba_pkg::IDLE;
        else                 ack_d   = 1'b1;
      end
      default:                 state_d = karatsuba_pkg::IDLE;
    endcase
  end

  assign ack_o = ack_q;

  // Control word per state ------------------------------
  always_comb begin
    load_reg1_o   = 1'b0;
    load_reg2_o   = 1'b0;
    load_reg3_o   = 1'b0;
    load_reg4_o   = 1'b0;
    sel_reg1_o    = 1'b0;
    sel_reg2_o    = 1'b0;
    sel_reg3_o    = 1'b0;
    sel_reg4_o    = 1'b0;
    sel_alu_a_o   = karatsuba_pkg::A_REG1_HI;
    sel_alu_b_o   = karatsuba_pkg::B_REG1_LO;
    sel_alu_b2_o  = 1'b0;
    shift5_o      = 1'b0;
    sel_mult_a_o  = 1'b0;
    sel_mult_a2_o = 1'b0;
    sel_mult_b_o  = 1'b0;
    sel_mult_b1_o = 1'b0;
    sub_o         = 1'b0;
    case (state_q)
      karatsuba_pkg::IDLE: begin
        load_reg1_o = req_i;  // Operands captured on the accepting edge.
        load_reg2_o = req_i;
      end
      karatsuba_pkg::SUM_A: begin
        load_reg4_o = 1'b1;
        sel_reg4_o  = 1'b1;
      end
      karatsuba_pkg::PROD_HI: begin  // z2.
        load_reg3_o  = 1'b1;
        sel_mult_a_o = 1'b1;
        sel_mult_b_o = 1'b1;
      end
      karatsuba_pkg::PROD_LO: begin  // z0.
        load_reg1_o = 1'b1;
        sel_reg1_o  = 1'b1;
      end
      karatsuba_pkg::SUM_B: begin
        load_reg2_o = 1'b1;
        sel_reg2_o  = 1'b1;
        sel_alu_a_o = karatsuba_pkg::A_REG2_HI;
        sel_alu_b_o = karatsuba_pkg::B_REG2_LO;
      end
      karatsuba_pkg::PROD_MID: begin
        load_reg4_o   = 1'b1;
        sel_mult_a_o  = 1'b1;
        sel_mult_a2_o = 1'b1;
        sel_mult_b_o  = 1'b1;
        sel_mult_b1_o = 1'b1;
      end
      karatsuba_pkg::SUB_LO: begin
        load_reg4_o  = 1'b1;
        sel_reg4_o   = 1'b1;
        sel_alu_a_o  = karatsuba_pkg::A_REG4;
        sel_alu_b_o  = karatsuba_pkg::B_ALT;
        sel_alu_b2_o = 1'b0;  // z0 from reg1.
        sub_o        = 1'b1;
      end
      karatsuba_pkg::SUB_HI: begin
        load_reg4_o = 1'b1;
        sel_reg4_o  = 1'b1;
        sel_alu_a_o = karatsuba_pkg::A_REG4;
        sel_alu_b_o = karatsuba_pkg::B_REG3_SHIFTED;
        sub_o       = 1'b1;
      end
      karatsuba_pkg::HORNER_1: begin
        load_reg3_o = 1'b1;
        sel_reg3_o  = 1'b1;
        sel_alu_a_o = karatsuba_pkg::A_REG4;
        sel_alu_b_o = karatsuba_pkg::B_REG3_SHIFTED;
        shift5_o    = 1'b1;
      end
      karatsuba_pkg::HORNER_2: begin
        load_reg3_o  = 1'b1;
        sel_reg3_o   = 1'b1;
        sel_alu_a_o  = karatsuba_pkg::A_REG3_SHIFTED;
        sel_alu_b_o  = karatsuba_pkg::B_ALT;
        sel_alu_b2_o = 1'b0;
        shift5_o     = 1'b1;
      end
      default: ;
    endcase
  end

  a_ack_in_done: assert property (@(posedge clk) disable iff (!arst_n_i)
    ack_o |-> (state_q == karatsuba_pkg::DONE))
    else $error("ack outside DONE.");

  // Four-phase rule: req stays up until ack is given.
  a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
    ((state_q != karatsuba_pkg::IDLE) && !ack_o) |-> req_i)
    else $error("req dropped while busy.");

endmodule

/* verilog/karatsuba_10b_top.sv */
`timescale 1ns/1ps

module karatsuba_10b_top #(
  parameter int OPERAND_W = karatsuba_pkg::OPERAND_W,
  parameter int LUT_W     = karatsuba_pkg::LUT_W,
  parameter int PRODUCT_W = karatsuba_pkg::PRODUCT_W
) (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 req_i,
  input  logic [OPERAND_W-1:0] a_i,
  input  logic [OPERAND_W-1:0] b_i,
  output logic                 ack_o,
  output logic [PRODUCT_W-1:0] product_o
);

  logic                      load_reg1, load_reg2, load_reg3, load_reg4;
  logic                      sel_reg1, sel_reg2, sel_reg3, sel_reg4;
  karatsuba_pkg::alu_a_sel_e sel_alu_a;
  karatsuba_pkg::alu_b_sel_e sel_alu_b;
  logic                      sel_alu_b2, shift5;
  logic                      sel_mult_a, sel_mult_a2, sel_mult_b, sel_mult_b1;
  logic                      sub;

  karatsuba_10b_ctrl u_ctrl (
    .clk (clk), .arst_n_i (arst_n_i), .req_i (req_i), .ack_o (ack_o),
    .load_reg1_o (load_reg1), .load_reg2_o (load_reg2),
    .load_reg3_o (load_reg3), .load_reg4_o (load_reg4),
    .sel_reg1_o (sel_reg1), .sel_reg2_o (sel_reg2),
    .sel_reg3_o (sel_reg3), .sel_reg4_o (sel_reg4),
    .sel_alu_a_o (sel_alu_a), .sel_alu_b_o (sel_alu_b),
    .sel_alu_b2_o (sel_alu_b2), .shift5_o (shift5),
    .sel_mult_a_o (sel_mult_a), .sel_mult_a2_o (sel_mult_a2),
    .sel_mult_b_o (sel_mult_b), .sel_mult_b1_o (sel_mult_b1),
    .sub_o (sub)
  );

  karatsuba_10b_dp #(
    .OPERAND_W (OPERAND_W), .LUT_W (LUT_W), .PRODUCT_W (PRODUCT_W)
  ) u_dp (
    .clk (clk), .a_i (a_i), .b_i (b_i),
    .load_reg1_i (load_reg1), .load_reg2_i (load_reg2),
    .load_reg3_i (load_reg3), .load_reg4_i (load_reg4),
    .sel_reg1_i (sel_reg1), .sel_reg2_i (sel_reg2),
    .sel_reg3_i (sel_reg3), .sel_reg4_i (sel_reg4),
    .sel_alu_a_i (sel_alu_a), .sel_alu_b_i (sel_alu_b),
    .sel_alu_b2_i (sel_alu_b2), .shift5_i (shift5),
    .sel_mult_a_i (sel_mult_a), .sel_mult_a2_i (sel_mult_a2),
    .sel_mult_b_i (sel_mult_b), .sel_mult_b1_i (sel_mult_b1),
    .sub_i (sub), .product_o (product_o)
  );

endmodule

/* dv/karatsuba_tb.sv */
`timescale 1ns/1ps

module karatsuba_tb;

  localparam int    OPERAND_W   = karatsuba_pkg::OPERAND_W;
  localparam int    PRODUCT_W   = karatsuba_pkg::PRODUCT_W;
  localparam int    LATENCY     = 10;    // Accepting edge to ack rise.
  localparam int    WAIT_LIMIT  = 50;
  localparam int    RANDOM_RUNS = 200;
  localparam string TRACE_PATH  = "dv/karatsuba_trace.txt";

  logic                 clk;
  logic                 arst_n_i;
  logic                 req_i;
  logic [OPERAND_W-1:0] a_i;
  logic [OPERAND_W-1:0] b_i;
  logic                 ack_o;
  logic [PRODUCT_W-1:0] product_o;

  logic [31:0]          lfsr_q;
  logic [OPERAND_W-1:0] trace_a [$];
  logic [OPERAND_W-1:0] trace_b [$];
  logic [PRODUCT_W-1:0] trace_p [$];

  karatsuba_10b_top #(
    .OPERAND_W (OPERAND_W),
    .PRODUCT_W (PRODUCT_W)
  ) DUT (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .ack_o     (ack_o),
    .product_o (product_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Helpers ------------------------------
  // Taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped.");
  endtask

  task automatic compare_product(input string name,
                                 input logic [karatsuba_pkg::PRODUCT_W-1:0] actual,
                                 input logic [karatsuba_pkg::PRODUCT_W-1:0] expected);
    if (actual !== expected)
      abort_run($sformatf("ERROR: %s = 0x%05h, expected 0x%05h", name, actual, expected));
  endtask

  task automatic compare_latency(input string name, input int actual, input int expected);
    if (actual != expected)
      abort_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  task automatic compare_ack(input string name, input logic actual, input logic expected);
    if (actual !== expected)
      abort_run($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, actual, expected));
  endtask

  task automatic read_trace();
    int                   fd;
    int                   fields;
    string                line;
    logic [OPERAND_W-1:0] a_val;
    logic [OPERAND_W-1:0] b_val;
    logic [PRODUCT_W-1:0] p_val;

    fd = $fopen(TRACE_PATH, "r");
    if (fd == 0) abort_run($sformatf("Could not open the trace file %s.", TRACE_PATH));
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) break;
      fields = $sscanf(line, "%h %h %h", a_val, b_val, p_val);
      if (fields == 3) begin  // Comment lines do not parse.
        trace_a.push_back(a_val);
        trace_b.push_back(b_val);
        trace_p.push_back(p_val);
      end
    end
    $fclose(fd);
    if (trace_a.size() == 0) abort_run("The trace file holds no vectors.");
  endtask

  // One four-phase transaction, started just after a falling edge.
  task automatic run_transaction(input logic [OPERAND_W-1:0] a_val,
                                 input logic [OPERAND_W-1:0] b_val,
                                 input logic [PRODUCT_W-1:0] expected);
    logic [31:0] junk;
    logic [31:0] hold;
    int          cycles;

    a_i   = a_val;
    b_i   = b_val;
    req_i = 1'b1;
    @(negedge clk);  // Accepting edge has passed.
    compare_ack("ack_o", ack_o, 1'b0);
    draw_bits(2 * OPERAND_W, junk);
    a_i = junk[2*OPERAND_W-1:OPERAND_W];  // Operands must be ignored now.
    b_i = junk[OPERAND_W-1:0];

    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for ack_o to rise.");
    end while (!ack_o);
    compare_latency("ack_o rise latency", cycles, LATENCY);
    compare_product("product_o", product_o, expected);

    draw_bits(3, hold);
    repeat (hold) begin
      @(negedge clk);
      compare_ack("ack_o", ack_o, 1'b1);
      compare_product("product_o", product_o, expected);
    end

    req_i  = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for ack_o to fall.");
    end while (ack_o);
    compare_latency("ack_o fall latency", cycles, 1);
  endtask

  // Main sequence ------------------------------
  initial begin
    logic [31:0]          bits;
    logic [OPERAND_W-1:0] a_val;
    logic [OPERAND_W-1:0] b_val;

    arst_n_i = 1'b0;
    req_i    = 1'b0;
    a_i      = '0;
    b_i      = '0;
    lfsr_q   = 32'h777e_cd7d;

    read_trace();
    repeat (3) @(negedge clk);
    compare_ack("ack_o", ack_o, 1'b0);
    arst_n_i = 1'b1;

    repeat (4) begin  // Idle with req low.
      @(negedge clk);
      compare_ack("ack_o", ack_o, 1'b0);
    end

    foreach (trace_a[i]) run_transaction(trace_a[i], trace_b[i], trace_p[i]);

    for (int n = 0; n < RANDOM_RUNS; n++) begin
      draw_bits(OPERAND_W, bits);
      a_val = bits[OPERAND_W-1:0];
      draw_bits(OPERAND_W, bits);
      b_val = bits[OPERAND_W-1:0];
      run_transaction(a_val, b_val, PRODUCT_W'(a_val) * PRODUCT_W'(b_val));
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* dv/karatsuba_trace.txt */
// Columns: a (10-bit hex), b (10-bit hex), expected product (20-bit hex).
// Edge operands first, then halves whose sums carry into bit 5.
000 000 00000
001 001 00001
3FF 3FF FF801
3FF 001 003FF
001 3FF 003FF
3FF 000 00000
020 020 00400
01F 01F 003C1
3E0 3E0 F0400
3FF 3E0 F7C20
01F 3E0 07820
3E0 01F 07820
2AA 155 38C72
155 2AA 38C72
123 0AB 0C261
200 200 40000
1FF 3F0 7DC10
064 0C8 04E20
3E8 3E8 F4240
21F 3F1 85C2F

/* tb.f */
verilog/karatsuba_pkg.sv
verilog/cla_adder.sv
verilog/mult_lut.sv
verilog/karatsuba_10b_dp.sv
verilog/karatsuba_10b_ctrl.sv
verilog/karatsuba_10b_top.sv
dv/karatsuba_tb.sv

/* Makefile */
# Verilator flow for the Karatsuba multiplier testbench.

VERILATOR ?= verilator
TOP       ?= karatsuba_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
